// ==== common/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

   // bus widths
   localparam int HOST_ADDR_W  = 30;
   localparam int ADDR_W       = 32;
   localparam int DATA_W       = 32;
   localparam int CSR_ADDR_W   = 3;

   // the profiler keeps one bit per 8 MB region of the 1 GB window
   localparam int PROF_REGIONS = 128;
   localparam int PROF_WORDS   = 4;
   localparam int PROF_IDX_HI  = 29;

   // address map
   localparam int HOST_WIN_BIT = 29;
   localparam logic [ADDR_W-1:0] CORE_DRAM_BASE  = 32'h8000_0000;
   localparam logic [ADDR_W-1:0] MEM_UPPER_LIMIT = 241 * 1024 * 1024;

   // control register word indices
   localparam logic [CSR_ADDR_W-1:0] CSR_CTRL       = 3'd0;
   localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_VALID = 3'd1;
   localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_BASE  = 3'd2;
   localparam logic [CSR_ADDR_W-1:0] CSR_PROF0      = 3'd3;

   typedef struct packed {
      logic [HOST_ADDR_W-1:0] addr;
      logic                   we;
      logic [DATA_W-1:0]      data;
   } host_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              we;
      logic [DATA_W-1:0] data;
   } core_req_t;

   // rebased request headed for the PS DRAM
   typedef struct packed {
      core_req_t req;
      logic      over_limit;
   } dram_req_t;

endpackage

`default_nettype wire

// ==== rtl/fp_slice.sv ====
`default_nettype none

module fp_slice #(
   parameter type payload_t = logic
) (
   input  wire      aclk_i,
   input  wire      rst_i,
   input  wire      payload_t in_i,
   input  wire      in_req_i,
   output logic     in_ack_o,
   output payload_t out_o,
   output logic     out_req_o,
   input  wire      out_ack_i,
   output logic     accept_o
);

   typedef enum logic [1:0] {
      idle_s,
      captured_s,
      sending_s,
      draining_s
   } state_t;

   state_t   state_q;
   state_t   state_d;
   logic     in_ack_q;
   payload_t payload_q;

   // only take a new item once the previous input handshake has fully closed
   assign accept_o  = (state_q == idle_s) && in_req_i && !in_ack_q;
   assign in_ack_o  = in_ack_q;
   assign out_req_o = (state_q == sending_s);
   assign out_o     = payload_q;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         idle_s:
         begin
            if (accept_o)
               state_d = captured_s;
         end
         captured_s:
            state_d = sending_s;
         sending_s:
         begin
            if (out_ack_i)
               state_d = draining_s;
         end
         default:
         begin
            // wait for the receiver to release its ack
            if (!out_ack_i)
               state_d = idle_s;
         end
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         state_q  <= idle_s;
         in_ack_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (accept_o)
            in_ack_q <= 1'b1;
         else if (!in_req_i)
            in_ack_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (accept_o)
         payload_q <= in_i;
   end

endmodule

`default_nettype wire

// ==== rtl/host_xlate_stage.sv ====
`default_nettype none

module host_xlate_stage (
   input  wire                   aclk_i,
   input  wire                   rst_i,
   input  wire bridge_pkg::host_req_t host_req_i,
   input  wire                   host_req_req_i,
   output logic                  host_req_ack_o,
   output bridge_pkg::core_req_t core_req_o,
   output logic                  core_req_req_o,
   input  wire                   core_req_ack_i
);

   bridge_pkg::core_req_t xlate_req;

   // window 0 of the host lands on core DRAM, window 1 on the core's local space
   always_comb
   begin
      xlate_req.addr = {~host_req_i.addr[bridge_pkg::HOST_WIN_BIT], 3'b000,
                        host_req_i.addr[bridge_pkg::HOST_WIN_BIT-2:0]};
      xlate_req.we   = host_req_i.we;
      xlate_req.data = host_req_i.data;
   end

   fp_slice #(
      .payload_t (bridge_pkg::core_req_t)
   ) i_slice (
      .aclk_i    (aclk_i),
      .rst_i     (rst_i),
      .in_i      (xlate_req),
      .in_req_i  (host_req_req_i),
      .in_ack_o  (host_req_ack_o),
      .out_o     (core_req_o),
      .out_req_o (core_req_req_o),
      .out_ack_i (core_req_ack_i),
      .accept_o  ()
   );

endmodule

`default_nettype wire

// ==== dram/dram_profile_stage.sv ====
`default_nettype none

module dram_profile_stage (
   input  wire                   aclk_i,
   input  wire                   rst_i,
   input  wire                   core_reset_i,
   input  wire bridge_pkg::core_req_t in_i,
   input  wire                   in_req_i,
   output logic                  in_ack_o,
   output bridge_pkg::core_req_t out_o,
   output logic                  out_req_o,
   input  wire                   out_ack_i,
   output logic [bridge_pkg::PROF_REGIONS-1:0] profile_o
);

   localparam int IDX_W = $clog2(bridge_pkg::PROF_REGIONS);

   logic                                  flush;
   logic                                  accept;
   logic [IDX_W-1:0]                      prof_idx;
   logic [bridge_pkg::PROF_REGIONS-1:0]   profile_q;

   // a core reset drops whatever is in flight
   assign flush     = rst_i || core_reset_i;
   assign prof_idx  = in_i.addr[bridge_pkg::PROF_IDX_HI -: IDX_W];
   assign profile_o = profile_q;

   fp_slice #(
      .payload_t (bridge_pkg::core_req_t)
   ) i_slice (
      .aclk_i    (aclk_i),
      .rst_i     (flush),
      .in_i      (in_i),
      .in_req_i  (in_req_i),
      .in_ack_o  (in_ack_o),
      .out_o     (out_o),
      .out_req_o (out_req_o),
      .out_ack_i (out_ack_i),
      .accept_o  (accept)
   );

   // the sticky bitmap keeps one bit per region touched since the last core reset
   always_ff @(posedge aclk_i)
   begin
      if (flush)
         profile_q <= '0;
      else if (accept)
         profile_q[prof_idx] <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== dram/dram_rebase_stage.sv ====
`default_nettype none

module dram_rebase_stage (
   input  wire                   aclk_i,
   input  wire                   rst_i,
   input  wire                   core_reset_i,
   input  wire [bridge_pkg::ADDR_W-1:0] dram_base_i,
   input  wire bridge_pkg::core_req_t in_i,
   input  wire                   in_req_i,
   output logic                  in_ack_o,
   output bridge_pkg::dram_req_t out_o,
   output logic                  out_req_o,
   input  wire                   out_ack_i
);

   logic                          flush;
   logic [bridge_pkg::ADDR_W-1:0] offset;
   bridge_pkg::dram_req_t         rebased;

   assign flush = rst_i || core_reset_i;

   // offset into the core's DRAM window, then moved onto the allocated PS buffer
   assign offset = in_i.addr ^ bridge_pkg::CORE_DRAM_BASE;

   always_comb
   begin
      rebased.req      = in_i;
      rebased.req.addr = offset + dram_base_i;
      // anything past the allocated buffer gets flagged for the host
      rebased.over_limit = (offset >= bridge_pkg::MEM_UPPER_LIMIT);
   end

   // the base is sampled along with the payload, so a late base write cannot
   // tear an item that is already held
   fp_slice #(
      .payload_t (bridge_pkg::dram_req_t)
   ) i_slice (
      .aclk_i    (aclk_i),
      .rst_i     (flush),
      .in_i      (rebased),
      .in_req_i  (in_req_i),
      .in_ack_o  (in_ack_o),
      .out_o     (out_o),
      .out_req_o (out_req_o),
      .out_ack_i (out_ack_i),
      .accept_o  ()
   );

endmodule

`default_nettype wire

// ==== rtl/shell_csr.sv ====
`default_nettype none

module shell_csr (
   input  wire                               aclk_i,
   input  wire                               rst_i,
   input  wire                               csr_we_i,
   input  wire [bridge_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
   input  wire [bridge_pkg::DATA_W-1:0]      csr_wdata_i,
   output logic [bridge_pkg::DATA_W-1:0]     csr_rdata_o,
   input  wire [bridge_pkg::PROF_REGIONS-1:0] profile_i,
   output logic [bridge_pkg::ADDR_W-1:0]     dram_base_o,
   output logic                              core_reset_o
);

   localparam int SEL_W = $clog2(bridge_pkg::PROF_WORDS);

   logic [bridge_pkg::DATA_W-1:0]                         ctrl_q;
   logic [bridge_pkg::DATA_W-1:0]                         dram_valid_q;
   logic [bridge_pkg::DATA_W-1:0]                         dram_base_q;
   logic [bridge_pkg::PROF_WORDS-1:0][bridge_pkg::DATA_W-1:0] prof_words;
   logic [bridge_pkg::CSR_ADDR_W-1:0]                     prof_word;

   assign prof_words = profile_i;
   assign prof_word  = csr_addr_i - bridge_pkg::CSR_PROF0;

   // the core stays in reset until the host sets ctrl bit 0
   assign core_reset_o = rst_i || !ctrl_q[0];
   assign dram_base_o  = dram_base_q;

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         ctrl_q       <= '0;
         dram_valid_q <= '0;
         dram_base_q  <= '0;
      end
      else if (csr_we_i)
      begin
         case (csr_addr_i)
            bridge_pkg::CSR_CTRL:       ctrl_q       <= csr_wdata_i;
            bridge_pkg::CSR_DRAM_VALID: dram_valid_q <= csr_wdata_i;
            bridge_pkg::CSR_DRAM_BASE:  dram_base_q  <= csr_wdata_i;
            default:                    ;
         endcase
      end
   end

   always_comb
   begin
      csr_rdata_o = '0;
      case (csr_addr_i)
         bridge_pkg::CSR_CTRL:       csr_rdata_o = ctrl_q;
         bridge_pkg::CSR_DRAM_VALID: csr_rdata_o = dram_valid_q;
         bridge_pkg::CSR_DRAM_BASE:  csr_rdata_o = dram_base_q;
         default:
         begin
            // profiler slices follow the writable words with the lowest regions first
            if (prof_word < bridge_pkg::PROF_WORDS)
               csr_rdata_o = prof_words[prof_word[SEL_W-1:0]];
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/zynq_bridge_top.sv ====
`default_nettype none

module zynq_bridge_top (
   input  wire                               aclk_i,
   input  wire                               rst_i,

   // host window accesses into the core
   input  wire bridge_pkg::host_req_t        host_req_i,
   input  wire                               host_req_req_i,
   output logic                              host_req_ack_o,
   output bridge_pkg::core_req_t             core_req_o,
   output logic                              core_req_req_o,
   input  wire                               core_req_ack_i,

   // core DRAM traffic out to the PS memory
   input  wire bridge_pkg::core_req_t        dram_in_i,
   input  wire                               dram_in_req_i,
   output logic                              dram_in_ack_o,
   output bridge_pkg::dram_req_t             dram_out_o,
   output logic                              dram_out_req_o,
   input  wire                               dram_out_ack_i,

   // control registers
   input  wire                               csr_we_i,
   input  wire [bridge_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
   input  wire [bridge_pkg::DATA_W-1:0]      csr_wdata_i,
   output logic [bridge_pkg::DATA_W-1:0]     csr_rdata_o,
   output logic                              core_reset_o
);

   bridge_pkg::core_req_t               prof_req;
   logic                                prof_req_req;
   logic                                prof_req_ack;
   logic [bridge_pkg::PROF_REGIONS-1:0] profile;
   logic [bridge_pkg::ADDR_W-1:0]       dram_base;
   logic                                core_reset;

   assign core_reset_o = core_reset;

   host_xlate_stage i_host_xlate_stage (
      .aclk_i         (aclk_i),
      .rst_i          (rst_i),
      .host_req_i     (host_req_i),
      .host_req_req_i (host_req_req_i),
      .host_req_ack_o (host_req_ack_o),
      .core_req_o     (core_req_o),
      .core_req_req_o (core_req_req_o),
      .core_req_ack_i (core_req_ack_i)
   );

   dram_profile_stage i_dram_profile_stage (
      .aclk_i       (aclk_i),
      .rst_i        (rst_i),
      .core_reset_i (core_reset),
      .in_i         (dram_in_i),
      .in_req_i     (dram_in_req_i),
      .in_ack_o     (dram_in_ack_o),
      .out_o        (prof_req),
      .out_req_o    (prof_req_req),
      .out_ack_i    (prof_req_ack),
      .profile_o    (profile)
   );

   dram_rebase_stage i_dram_rebase_stage (
      .aclk_i       (aclk_i),
      .rst_i        (rst_i),
      .core_reset_i (core_reset),
      .dram_base_i  (dram_base),
      .in_i         (prof_req),
      .in_req_i     (prof_req_req),
      .in_ack_o     (prof_req_ack),
      .out_o        (dram_out_o),
      .out_req_o    (dram_out_req_o),
      .out_ack_i    (dram_out_ack_i)
   );

   shell_csr i_shell_csr (
      .aclk_i       (aclk_i),
      .rst_i        (rst_i),
      .csr_we_i     (csr_we_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rdata_o  (csr_rdata_o),
      .profile_i    (profile),
      .dram_base_o  (dram_base),
      .core_reset_o (core_reset)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_zynq_bridge.sv ====
`default_nettype none

module tb_zynq_bridge;

   logic                              aclk;
   logic                              rst;
   bridge_pkg::host_req_t             host_req;
   logic                              host_req_req;
   logic                              host_req_ack;
   bridge_pkg::core_req_t             core_req;
   logic                              core_req_req;
   logic                              core_req_ack;
   bridge_pkg::core_req_t             dram_in;
   logic                              dram_in_req;
   logic                              dram_in_ack;
   bridge_pkg::dram_req_t             dram_out;
   logic                              dram_out_req;
   logic                              dram_out_ack;
   logic                              csr_we;
   logic [bridge_pkg::CSR_ADDR_W-1:0] csr_addr;
   logic [bridge_pkg::DATA_W-1:0]     csr_wdata;
   logic [bridge_pkg::DATA_W-1:0]     csr_rdata;
   logic                              core_reset;

   // the test table holds one entry per line of the data file
   string            op_q[$];
   string            name_q[$];
   logic [4:0][31:0] field_q[$];

   // results still owed by each output link in arrival order
   bridge_pkg::core_req_t core_exp_q[$];
   string                 core_name_q[$];
   bridge_pkg::dram_req_t dram_exp_q[$];
   string                 dram_name_q[$];

   logic [31:0] lcg_state = 32'hf5d11de6;
   int          cycle_count = 0;
   int          timeout_limit = 0;
   bit          tests_loaded = 1'b0;

   zynq_bridge_top i_zynq_bridge_top (
      .aclk_i         (aclk),
      .rst_i          (rst),
      .host_req_i     (host_req),
      .host_req_req_i (host_req_req),
      .host_req_ack_o (host_req_ack),
      .core_req_o     (core_req),
      .core_req_req_o (core_req_req),
      .core_req_ack_i (core_req_ack),
      .dram_in_i      (dram_in),
      .dram_in_req_i  (dram_in_req),
      .dram_in_ack_o  (dram_in_ack),
      .dram_out_o     (dram_out),
      .dram_out_req_o (dram_out_req),
      .dram_out_ack_i (dram_out_ack),
      .csr_we_i       (csr_we),
      .csr_addr_i     (csr_addr),
      .csr_wdata_i    (csr_wdata),
      .csr_rdata_o    (csr_rdata),
      .core_reset_o   (core_reset)
   );

   initial
   begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_core_req(input string name, input bridge_pkg::core_req_t exp,
                                 input bridge_pkg::core_req_t act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_dram_req(input string name, input bridge_pkg::dram_req_t exp,
                                 input bridge_pkg::dram_req_t act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_csr(input string name, input logic [bridge_pkg::DATA_W-1:0] exp,
                            input logic [bridge_pkg::DATA_W-1:0] act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_reset(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s core reset: expected %b, actual %b", name, exp, act));
   endtask

   // responder delay of 0 to 3 cycles from the upper LCG bits
   function automatic int unsigned next_delay();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[17:16];
   endfunction

   task automatic load_tests();
      int          fd;
      int          count;
      string       line;
      string       op;
      string       name;
      logic [31:0] f0, f1, f2, f3, f4;
      fd = $fopen("testbench/bridge_tests.txt", "r");
      if (fd == 0)
         abort_run("could not open the test file testbench/bridge_tests.txt");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         count = $sscanf(line, "%s %s %h %h %h %h %h", op, name, f0, f1, f2, f3, f4);
         if (count != 7)
            abort_run({"malformed line in the test file: ", line});
         op_q.push_back(op);
         name_q.push_back(name);
         field_q.push_back({f4, f3, f2, f1, f0});
      end
      $fclose(fd);
   endtask

   // CSR accesses only make sense once both request paths are empty
   // and both output handshakes have closed
   task automatic wait_idle();
      while (core_exp_q.size() != 0 || dram_exp_q.size() != 0 ||
             core_req_req || core_req_ack || dram_out_req || dram_out_ack)
         @(posedge aclk);
   endtask

   task automatic write_csr(input logic [bridge_pkg::CSR_ADDR_W-1:0] addr,
                            input logic [bridge_pkg::DATA_W-1:0] data);
      @(posedge aclk);
      csr_we    <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= data;
      @(posedge aclk);
      csr_we    <= 1'b0;
   endtask

   task automatic read_csr(input string name, input logic [bridge_pkg::CSR_ADDR_W-1:0] addr,
                           input logic [bridge_pkg::DATA_W-1:0] exp, input logic exp_reset);
      @(posedge aclk);
      csr_addr <= addr;
      @(posedge aclk);
      check_csr(name, exp, csr_rdata);
      check_reset(name, exp_reset, core_reset);
   endtask

   task automatic send_host(input bridge_pkg::host_req_t req);
      @(posedge aclk);
      host_req     <= req;
      host_req_req <= 1'b1;
      do
         @(posedge aclk);
      while (!host_req_ack);
      host_req_req <= 1'b0;
      do
         @(posedge aclk);
      while (host_req_ack);
   endtask

   task automatic send_dram(input bridge_pkg::core_req_t req);
      @(posedge aclk);
      dram_in     <= req;
      dram_in_req <= 1'b1;
      do
         @(posedge aclk);
      while (!dram_in_ack);
      dram_in_req <= 1'b0;
      do
         @(posedge aclk);
      while (dram_in_ack);
   endtask

   initial
   begin : core_responder
      int unsigned delay;
      forever
      begin
         @(posedge aclk);
         if (core_req_req)
         begin
            if (core_exp_q.size() == 0)
               abort_run("a core request came out with no host request outstanding");
            check_core_req(core_name_q.pop_front(), core_exp_q.pop_front(), core_req);
            delay = next_delay();
            repeat (delay) @(posedge aclk);
            core_req_ack <= 1'b1;
            do
               @(posedge aclk);
            while (core_req_req);
            core_req_ack <= 1'b0;
         end
      end
   end

   initial
   begin : dram_responder
      int unsigned delay;
      forever
      begin
         @(posedge aclk);
         if (dram_out_req)
         begin
            if (dram_exp_q.size() == 0)
               abort_run("a DRAM request came out with no core request outstanding");
            check_dram_req(dram_name_q.pop_front(), dram_exp_q.pop_front(), dram_out);
            delay = next_delay();
            repeat (delay) @(posedge aclk);
            dram_out_ack <= 1'b1;
            do
               @(posedge aclk);
            while (dram_out_req);
            dram_out_ack <= 1'b0;
         end
      end
   end

   always @(posedge aclk)
   begin
      cycle_count <= cycle_count + 1;
      if (tests_loaded && cycle_count >= timeout_limit)
         abort_run("timeout: the tests did not finish within the cycle limit");
   end

   initial
   begin : main
      logic [4:0][31:0]      f;
      bridge_pkg::host_req_t hreq;
      bridge_pkg::core_req_t creq;
      bridge_pkg::dram_req_t dreq;
      rst          = 1'b1;
      host_req     = '0;
      host_req_req = 1'b0;
      core_req_ack = 1'b0;
      dram_in      = '0;
      dram_in_req  = 1'b0;
      dram_out_ack = 1'b0;
      csr_we       = 1'b0;
      csr_addr     = '0;
      csr_wdata    = '0;
      load_tests();
      timeout_limit = 40 * op_q.size() + 100;
      tests_loaded  = 1'b1;
      repeat (10) @(posedge aclk);
      rst <= 1'b0;
      for (int i = 0; i < op_q.size(); i++)
      begin
         f = field_q[i];
         case (op_q[i])
            "CSRW":
            begin
               wait_idle();
               write_csr(f[0][bridge_pkg::CSR_ADDR_W-1:0], f[1]);
            end
            "CSRR":
            begin
               wait_idle();
               read_csr(name_q[i], f[0][bridge_pkg::CSR_ADDR_W-1:0], f[1], f[2][0]);
            end
            "HOST":
            begin
               hreq.addr = f[0][bridge_pkg::HOST_ADDR_W-1:0];
               hreq.we   = f[1][0];
               hreq.data = f[2];
               creq.addr = f[3];
               creq.we   = f[1][0];
               creq.data = f[2];
               core_exp_q.push_back(creq);
               core_name_q.push_back(name_q[i]);
               send_host(hreq);
            end
            "DRAM":
            begin
               creq.addr       = f[0];
               creq.we         = f[1][0];
               creq.data       = f[2];
               dreq.req        = creq;
               dreq.req.addr   = f[3];
               dreq.over_limit = f[4][0];
               dram_exp_q.push_back(dreq);
               dram_name_q.push_back(name_q[i]);
               send_dram(creq);
            end
            default:
               abort_run({"unknown op code in the test file: ", op_q[i]});
         endcase
      end
      wait_idle();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/bridge_tests.txt ====
# op name f0 f1 f2 f3 f4, every field in hex
# CSRW: addr wdata | CSRR: addr rdata core_reset | HOST, DRAM: addr we data exp_addr over_limit
CSRR reset_ctrl         0        00000000 1 00000000 0
CSRR reset_base         2        00000000 1 00000000 0
CSRR reset_prof0        3        00000000 1 00000000 0
HOST host_win0_lo       00001000 1 11112222 80001000 0
HOST host_win0_mid      0abcdef0 0 00000000 8abcdef0 0
HOST host_win0_top      0ffffffc 1 deadbeef 8ffffffc 0
HOST host_bit28_dropped 10000010 1 77777777 80000010 0
HOST host_win1_lo       20000000 1 a5a5a5a5 00000000 0
HOST host_win1_mid      21234568 0 00000000 01234568 0
HOST host_win1_top      2ffffffc 1 0badf00d 0ffffffc 0
CSRW set_base           2        18000000 0 00000000 0
CSRW set_valid          1        00000001 0 00000000 0
CSRW core_run           0        00000001 0 00000000 0
CSRR run_ctrl           0        00000001 0 00000000 0
CSRR run_valid          1        00000001 0 00000000 0
CSRR run_base           2        18000000 0 00000000 0
DRAM dram_base_start    80000000 1 00000001 18000000 0
DRAM dram_region1_lo    80800040 0 00000000 18800040 0
DRAM dram_region1_hi    80fffffc 1 12345678 18fffffc 0
DRAM dram_below_limit   8f0ffffc 1 cafef00d 270ffffc 0
DRAM dram_at_limit      8f100000 0 00000000 27100000 1
DRAM dram_far           90000000 1 55aa55aa 28000000 1
DRAM dram_local         00000100 0 00000000 98000100 1
DRAM dram_last_region   bffffffc 1 ffffffff 57fffffc 1
HOST mix_host_a         00000040 1 01010101 80000040 0
DRAM mix_dram_a         84000000 1 02020202 1c000000 0
HOST mix_host_b         20000080 0 00000000 00000080 0
DRAM mix_dram_b         a2a00010 0 00000000 3aa00010 1
DRAM mix_dram_c         8efffff0 1 03030303 26fffff0 0
CSRR prof_word0         3        60000103 0 00000000 0
CSRR prof_word1         4        00000001 0 00000000 0
CSRR prof_word2         5        00000020 0 00000000 0
CSRR prof_word3         6        80000000 0 00000000 0
CSRR unused_word        7        00000000 0 00000000 0
CSRW core_halt          0        00000000 0 00000000 0
CSRR halt_ctrl          0        00000000 1 00000000 0
CSRR halt_prof0         3        00000000 1 00000000 0
CSRR halt_prof1         4        00000000 1 00000000 0
CSRR halt_prof2         5        00000000 1 00000000 0
CSRR halt_prof3         6        00000000 1 00000000 0
CSRW set_base_high      2        f0000000 0 00000000 0
CSRW core_run_again     0        00000001 0 00000000 0
DRAM dram_wrap          98000000 1 44444444 08000000 1
DRAM dram_high_base     80000010 0 00000000 f0000010 0
CSRW ro_write           3        ffffffff 0 00000000 0
CSRR wrap_prof0         3        00000001 0 00000000 0
CSRR wrap_prof1         4        00010000 0 00000000 0

// ==== sources.f ====
common/bridge_pkg.sv
rtl/fp_slice.sv
rtl/host_xlate_stage.sv
dram/dram_profile_stage.sv
dram/dram_rebase_stage.sv
rtl/shell_csr.sv
rtl/zynq_bridge_top.sv
testbench/tb_zynq_bridge.sv
